// ==== alu_op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_op_decode import decode_pkg::*; (
    input  logic [31:0] instr,
    input  opcode_grp_e grp,
    output tube_sel_t   tube_sel,
    output alu_ctl_t    alu_ctl
);

    localparam logic [6:0] FUNCT7_MEXT = 7'b0000001;

    logic [2:0] funct3;
    logic       is_op;
    logic       is_mext;

    always_comb funct3  = instr[14:12];
    always_comb is_op   = (grp == GRP_OP);
    always_comb is_mext = is_op && (instr[31:25] == FUNCT7_MEXT);

    always_comb begin
        tube_sel = '0;
        unique case (grp)
            GRP_OP: begin
                if (is_mext) begin
                    tube_sel.tube_8c = funct3[2];   // DIV, DIVU, REM, REMU
                    tube_sel.tube_4c = ~funct3[2];  // MUL family
                end else begin
                    tube_sel.tube_0c = 1'b1;
                end
            end
            GRP_LOAD,
            GRP_STORE,
            GRP_OPIMM,
            GRP_BRANCH,
            GRP_JALR:   tube_sel.tube_0c = 1'b1;
            default:    tube_sel = '0;  // LUI, AUIPC, JAL use no tube
        endcase

        assert ($onehot0(tube_sel))
            else $error("alu_op_decode: tube_sel %b not one-hot", tube_sel);
    end

    always_comb begin
        alu_ctl = '{sign: 1'b0, inv2: 1'b0, cin: 1'b0, rsel: 2'd0, fsel: FSEL_ADD};
        if ((grp == GRP_OPIMM) || (is_op && !is_mext)) begin
            unique case (funct3)
                3'b000: begin  // ADD/SUB, only OP honours instr[30]
                    alu_ctl.sign = 1'b1;
                    alu_ctl.inv2 = is_op & instr[30];
                    alu_ctl.cin  = is_op & instr[30];
                end
                3'b001: alu_ctl.fsel = FSEL_SHIFT;
                3'b010: alu_ctl = '{sign: 1'b1, inv2: 1'b1, cin: 1'b1, rsel: 2'd2, fsel: FSEL_CMP};
                3'b011: alu_ctl = '{sign: 1'b0, inv2: 1'b1, cin: 1'b1, rsel: 2'd2, fsel: FSEL_CMP};
                3'b100: alu_ctl.fsel = FSEL_LOGIC;
                3'b101: alu_ctl = '{sign: instr[30], inv2: 1'b0, cin: 1'b0, rsel: 2'd2,
                                    fsel: FSEL_SHIFT};  // SRL/SRA
                3'b110: alu_ctl = '{sign: 1'b0, inv2: 1'b0, cin: 1'b0, rsel: 2'd2, fsel: FSEL_LOGIC};
                3'b111: alu_ctl = '{sign: 1'b0, inv2: 1'b0, cin: 1'b0, rsel: 2'd3, fsel: FSEL_LOGIC};
                default: ;
            endcase
        end else if (grp == GRP_BRANCH) begin
            alu_ctl.inv2 = 1'b1;
            alu_ctl.fsel = FSEL_CMP;
            unique case (funct3)
                3'b000: alu_ctl.rsel = 2'd0;  // BEQ
                3'b001: alu_ctl.rsel = 2'd1;  // BNE
                3'b100: alu_ctl = '{sign: 1'b1, inv2: 1'b1, cin: 1'b0, rsel: 2'd2, fsel: FSEL_CMP};
                3'b101: alu_ctl = '{sign: 1'b1, inv2: 1'b1, cin: 1'b0, rsel: 2'd3, fsel: FSEL_CMP};
                3'b110: alu_ctl.rsel = 2'd2;  // BLTU
                3'b111: alu_ctl.rsel = 2'd3;  // BGEU
                default: alu_ctl = '{sign: 1'b0, inv2: 1'b0, cin: 1'b0, rsel: 2'd0,
                                     fsel: FSEL_ADD};
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode import decode_pkg::*; #(
    parameter int unsigned TUBE_4C_DEPTH = 4,
    parameter int unsigned TUBE_8C_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  decode_in_t            in,
    input  logic [XLEN-1:0]       reg1,
    input  logic [XLEN-1:0]       reg2,
    output logic [REG_ADDR_W-1:0] reg1_rd_addr,
    output logic [REG_ADDR_W-1:0] reg2_rd_addr,
    output decode_out_t           out
);

    opcode_grp_e              grp;
    logic [XLEN-1:0]          imm;
    tube_sel_t                tube_sel;
    tube_sel_t                issued_sel;
    alu_ctl_t                 alu_ctl;
    logic [XLEN-1:0]          lane_a;
    logic [XLEN-1:0]          lane_b;
    logic [XLEN-1:0]          lane_c;
    logic [XLEN-1:0]          lane_d;
    logic                     lane_j_add_pc;
    logic                     lane_y_sel_j;
    logic                     lane_y_sel_k;
    logic                     issue;
    logic                     pc_wr_en;
    logic                     mem_rd_en;
    logic                     mem_wr_en;
    logic [BYTES_PER_REG-1:0] mem_wr_ben;
    logic                     reg_wr_en;

    always_comb reg1_rd_addr = in.instr[19:15];
    always_comb reg2_rd_addr = in.instr[24:20];

    opcode_decode i_opcode_decode (
        .instr       (in.instr),
        .instr_valid (in.instr_valid),
        .grp         (grp),
        .imm         (imm)
    );

    alu_op_decode i_alu_op_decode (
        .instr    (in.instr),
        .grp      (grp),
        .tube_sel (tube_sel),
        .alu_ctl  (alu_ctl)
    );

    operand_lanes i_operand_lanes (
        .grp           (grp),
        .pc            (in.pc),
        .imm           (imm),
        .reg1          (reg1),
        .reg2          (reg2),
        .lane_a        (lane_a),
        .lane_b        (lane_b),
        .lane_c        (lane_c),
        .lane_d        (lane_d),
        .lane_j_add_pc (lane_j_add_pc),
        .lane_y_sel_j  (lane_y_sel_j),
        .lane_y_sel_k  (lane_y_sel_k)
    );

    issue_control #(
        .TUBE_4C_DEPTH (TUBE_4C_DEPTH),
        .TUBE_8C_DEPTH (TUBE_8C_DEPTH)
    ) i_issue_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .grp        (grp),
        .tube_sel   (tube_sel),
        .instr      (in.instr),
        .issue      (issue),
        .issued_sel (issued_sel),
        .pc_wr_en   (pc_wr_en),
        .mem_rd_en  (mem_rd_en),
        .mem_wr_en  (mem_wr_en),
        .mem_wr_ben (mem_wr_ben),
        .reg_wr_en  (reg_wr_en)
    );

    always_comb out = '{
        issue:           issue,
        tube_sel:        issued_sel,
        alu_ctl:         alu_ctl,
        pc_wr_en:        pc_wr_en,
        branch:          (grp == GRP_BRANCH),
        pc_sel_j:        (grp == GRP_JAL),
        pc_sel_k:        (grp == GRP_JALR),
        lane_y_sel_j:    lane_y_sel_j,
        lane_y_sel_k:    lane_y_sel_k,
        lane_j_add_pc:   lane_j_add_pc,
        mem_rd_en:       mem_rd_en,
        mem_wr_en:       mem_wr_en,
        mem_wr_ben:      mem_wr_ben,
        reg_wr_en:       reg_wr_en,
        reg_wr_size:     in.instr[13:12],  // Byte, half or word
        reg_wr_sign_ext: ~in.instr[14],
        reg_wr_addr:     in.instr[11:7],
        lane_a:          lane_a,
        lane_b:          lane_b,
        lane_c:          lane_c,
        lane_d:          lane_d
    };

endmodule

`default_nettype wire

// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    localparam int unsigned XLEN          = 32;
    localparam int unsigned REG_ADDR_W    = 5;
    localparam int unsigned BYTES_PER_REG = XLEN / 8;

    typedef enum logic [3:0] {
        GRP_NONE,
        GRP_LOAD,
        GRP_OPIMM,
        GRP_AUIPC,
        GRP_STORE,
        GRP_OP,
        GRP_LUI,
        GRP_BRANCH,
        GRP_JALR,
        GRP_JAL
    } opcode_grp_e;

    typedef enum logic [1:0] {
        FSEL_ADD,
        FSEL_CMP,
        FSEL_LOGIC,
        FSEL_SHIFT
    } alu_fsel_e;

    typedef struct packed {
        logic       sign;
        logic       inv2;  // Invert operand 2
        logic       cin;
        logic [1:0] rsel;  // Result select within the function unit
        alu_fsel_e  fsel;
    } alu_ctl_t;

    typedef struct packed {
        logic tube_0c;
        logic tube_4c;
        logic tube_8c;
    } tube_sel_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
    } tube_entry_t;

    typedef struct packed {
        logic            instr_valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } decode_in_t;

    typedef struct packed {
        logic                     issue;
        tube_sel_t                tube_sel;
        alu_ctl_t                 alu_ctl;
        logic                     pc_wr_en;
        logic                     branch;
        logic                     pc_sel_j;
        logic                     pc_sel_k;
        logic                     lane_y_sel_j;
        logic                     lane_y_sel_k;
        logic                     lane_j_add_pc;
        logic                     mem_rd_en;
        logic                     mem_wr_en;
        logic [BYTES_PER_REG-1:0] mem_wr_ben;
        logic                     reg_wr_en;
        logic [1:0]               reg_wr_size;
        logic                     reg_wr_sign_ext;
        logic [REG_ADDR_W-1:0]    reg_wr_addr;
        logic [XLEN-1:0]          lane_a;
        logic [XLEN-1:0]          lane_b;
        logic [XLEN-1:0]          lane_c;
        logic [XLEN-1:0]          lane_d;
    } decode_out_t;

endpackage

`default_nettype wire

// ==== flist.f ====
+incdir+.
decode_pkg.sv
opcode_decode.sv
alu_op_decode.sv
operand_lanes.sv
tube_tracker.sv
issue_control.sv
decode.sv
tb_decode.sv

// ==== issue_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_control import decode_pkg::*; #(
    parameter int unsigned TUBE_4C_DEPTH = 4,
    parameter int unsigned TUBE_8C_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  opcode_grp_e              grp,
    input  tube_sel_t                tube_sel,
    input  logic [31:0]              instr,
    output logic                     issue,
    output tube_sel_t                issued_sel,
    output logic                     pc_wr_en,
    output logic                     mem_rd_en,
    output logic                     mem_wr_en,
    output logic [BYTES_PER_REG-1:0] mem_wr_ben,
    output logic                     reg_wr_en
);

    // 8c entry here retires in the same cycle as a 4c issued now
    localparam int unsigned SLOT_M = TUBE_8C_DEPTH - TUBE_4C_DEPTH;

    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;

    tube_entry_t push_4c;
    tube_entry_t push_8c;
    tube_entry_t slots_4c [TUBE_4C_DEPTH];
    tube_entry_t slots_8c [TUBE_8C_DEPTH];

    logic collision;
    logic hazard;

    always_comb rs1 = instr[19:15];
    always_comb rs2 = instr[24:20];
    always_comb rd  = instr[11:7];

    always_comb push_4c = '{valid: issued_sel.tube_4c, rd: rd};
    always_comb push_8c = '{valid: issued_sel.tube_8c, rd: rd};

    tube_tracker #(.DEPTH(TUBE_4C_DEPTH)) i_tube_tracker_4c (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (push_4c),
        .slots (slots_4c)
    );

    tube_tracker #(.DEPTH(TUBE_8C_DEPTH)) i_tube_tracker_8c (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (push_8c),
        .slots (slots_8c)
    );

    // Writeback slot already claimed
    always_comb collision =
        (tube_sel.tube_0c & (slots_4c[0].valid | slots_8c[0].valid)) |
        (tube_sel.tube_4c & slots_8c[SLOT_M].valid);

    always_comb hazard = tube_sel.tube_0c & slots_8c[SLOT_M].valid &
        ((slots_8c[SLOT_M].rd == rs1) | (slots_8c[SLOT_M].rd == rs2) |
         (slots_8c[SLOT_M].rd == rd));

    always_comb issue      = (grp != GRP_NONE) & ~collision & ~hazard;
    always_comb issued_sel = issue ? tube_sel : '0;

    always_comb pc_wr_en  = issue;
    always_comb mem_rd_en = issue & (grp == GRP_LOAD);
    always_comb mem_wr_en = issue & (grp == GRP_STORE);
    always_comb reg_wr_en = issue & (grp inside {GRP_LOAD, GRP_OPIMM, GRP_AUIPC, GRP_OP,
                                                 GRP_LUI, GRP_JALR, GRP_JAL});

    always_comb begin
        mem_wr_ben = '0;
        if (mem_wr_en) begin
            unique case (instr[14:12])
                3'b000:  mem_wr_ben = BYTES_PER_REG'(4'b0001);  // SB
                3'b001:  mem_wr_ben = BYTES_PER_REG'(4'b0011);  // SH
                3'b010:  mem_wr_ben = BYTES_PER_REG'(4'b1111);  // SW
                default: mem_wr_ben = '0;
            endcase
        end
    end

    // A 0c result never shares writeback with a retiring 4c or 8c entry
    a_no_0c_wb_clash: assert property (@(posedge clk) disable iff (!rst_n)
        issued_sel.tube_0c |-> !(slots_4c[0].valid || slots_8c[0].valid))
        else $error("issue_control: 0c issued while a tube retires");

endmodule

`default_nettype wire

// ==== opcode_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module opcode_decode import decode_pkg::*; (
    input  logic [31:0]     instr,
    input  logic            instr_valid,
    output opcode_grp_e     grp,
    output logic [XLEN-1:0] imm
);

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OPIMM  = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    always_comb begin
        grp = GRP_NONE;
        if (instr_valid && (instr[1:0] == 2'b11)) begin  // 32-bit encodings only
            case (instr[6:0])
                OPC_LOAD:   grp = GRP_LOAD;
                OPC_OPIMM:  grp = GRP_OPIMM;
                OPC_AUIPC:  grp = GRP_AUIPC;
                OPC_STORE:  grp = GRP_STORE;
                OPC_OP:     grp = GRP_OP;
                OPC_LUI:    grp = GRP_LUI;
                OPC_BRANCH: grp = GRP_BRANCH;
                OPC_JALR:   grp = GRP_JALR;
                OPC_JAL:    grp = GRP_JAL;
                default:    grp = GRP_NONE;  // FP, AMO, SYSTEM, RV64 and the rest
            endcase
        end

        assert (grp == GRP_NONE || instr_valid)
            else $error("opcode_decode: group %s decoded without instr_valid", grp.name());
    end

    always_comb imm_i = {{(XLEN-11){instr[31]}}, instr[30:20]};
    always_comb imm_s = {{(XLEN-11){instr[31]}}, instr[30:25], instr[11:7]};
    always_comb imm_b = {{(XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    always_comb imm_u = {{(XLEN-31){instr[31]}}, instr[30:12], 12'b0};
    always_comb imm_j = {{(XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        unique case (grp)
            GRP_LOAD,
            GRP_OPIMM,
            GRP_JALR:   imm = imm_i;
            GRP_STORE:  imm = imm_s;
            GRP_BRANCH: imm = imm_b;
            GRP_LUI,
            GRP_AUIPC:  imm = imm_u;
            GRP_JAL:    imm = imm_j;
            default:    imm = '0;  // OP has no immediate
        endcase
    end

endmodule

`default_nettype wire

// ==== operand_lanes.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_lanes import decode_pkg::*; (
    input  opcode_grp_e     grp,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] reg1,
    input  logic [XLEN-1:0] reg2,
    output logic [XLEN-1:0] lane_a,
    output logic [XLEN-1:0] lane_b,
    output logic [XLEN-1:0] lane_c,
    output logic [XLEN-1:0] lane_d,
    output logic            lane_j_add_pc,
    output logic            lane_y_sel_j,
    output logic            lane_y_sel_k
);

    always_comb lane_a = pc;
    always_comb lane_c = reg1;

    always_comb begin
        unique case (grp)
            GRP_LOAD, GRP_AUIPC, GRP_LUI,
            GRP_BRANCH, GRP_JALR, GRP_JAL: lane_b = imm;
            GRP_STORE:                     lane_b = reg2;  // Store data
            default:                       lane_b = '0;
        endcase
    end

    always_comb begin
        unique case (grp)
            GRP_LOAD, GRP_OPIMM,
            GRP_STORE, GRP_JALR: lane_d = imm;  // Address offset or I-type operand
            GRP_OP, GRP_BRANCH:  lane_d = reg2;
            default:             lane_d = '0;
        endcase
    end

    always_comb lane_j_add_pc = grp inside {GRP_AUIPC, GRP_BRANCH, GRP_JAL};
    always_comb lane_y_sel_j  = grp inside {GRP_AUIPC, GRP_LUI};
    always_comb lane_y_sel_k  = grp inside {GRP_OPIMM, GRP_OP};  // ALU result to writeback

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the decode testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_decode -f flist.f -o tb_decode

./obj_dir/tb_decode | tee sim.log

# Exit status follows the testbench verdict
grep -qx "sim passed" sim.log

// ==== decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

tube_entry_t occ_4c[$];  // Index 0 retires this cycle
tube_entry_t occ_8c[$];

function automatic opcode_grp_e model_grp(input logic valid, input logic [31:0] i);
    if (!valid) return GRP_NONE;
    case (i[6:0])
        7'h03:   return GRP_LOAD;
        7'h13:   return GRP_OPIMM;
        7'h17:   return GRP_AUIPC;
        7'h23:   return GRP_STORE;
        7'h33:   return GRP_OP;
        7'h37:   return GRP_LUI;
        7'h63:   return GRP_BRANCH;
        7'h67:   return GRP_JALR;
        7'h6f:   return GRP_JAL;
        default: return GRP_NONE;
    endcase
endfunction

function automatic logic [31:0] model_imm(input opcode_grp_e g, input logic [31:0] i);
    case (g)
        GRP_LOAD, GRP_OPIMM, GRP_JALR: return 32'($signed(i[31:20]));
        GRP_STORE:                     return 32'($signed({i[31:25], i[11:7]}));
        GRP_BRANCH: return 32'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
        GRP_LUI, GRP_AUIPC:            return {i[31:12], 12'h000};
        GRP_JAL:    return 32'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
        default:                       return '0;
    endcase
endfunction

function automatic alu_ctl_t model_alu(input opcode_grp_e g, input logic [31:0] i);
    logic       sub;
    logic [2:0] f3;
    f3  = i[14:12];
    sub = (g == GRP_OP) && i[30];
    if (g == GRP_OPIMM || (g == GRP_OP && i[31:25] != 7'b0000001)) begin
        case (f3)
            3'd0:    return {1'b1, sub, sub, 2'd0, FSEL_ADD};
            3'd1:    return {1'b0, 1'b0, 1'b0, 2'd0, FSEL_SHIFT};
            3'd2:    return {1'b1, 1'b1, 1'b1, 2'd2, FSEL_CMP};
            3'd3:    return {1'b0, 1'b1, 1'b1, 2'd2, FSEL_CMP};
            3'd4:    return {1'b0, 1'b0, 1'b0, 2'd0, FSEL_LOGIC};
            3'd5:    return {i[30], 1'b0, 1'b0, 2'd2, FSEL_SHIFT};
            3'd6:    return {1'b0, 1'b0, 1'b0, 2'd2, FSEL_LOGIC};
            default: return {1'b0, 1'b0, 1'b0, 2'd3, FSEL_LOGIC};
        endcase
    end
    // Branch rsel is {lt/ge, ne/ge}, signed only for BLT and BGE
    if (g == GRP_BRANCH && f3[2:1] != 2'b01)
        return {f3[2] & ~f3[1], 1'b1, 1'b0, f3[2], f3[0], FSEL_CMP};
    return '0;
endfunction

function automatic decode_out_t model_out(input decode_in_t d, input logic [31:0] r1,
                                          input logic [31:0] r2);
    decode_out_t o;
    opcode_grp_e g;
    tube_sel_t   t;
    tube_entry_t m;
    logic [31:0] imm;
    logic        blocked;
    g   = model_grp(d.instr_valid, d.instr);
    imm = model_imm(g, d.instr);
    m   = occ_8c[SLOT_M];
    t   = '0;
    if (g == GRP_OP && d.instr[31:25] == 7'b0000001) begin
        t.tube_8c = d.instr[14];
        t.tube_4c = !d.instr[14];
    end else begin
        t.tube_0c = g inside {GRP_LOAD, GRP_STORE, GRP_OPIMM, GRP_OP, GRP_BRANCH, GRP_JALR};
    end
    blocked = (t.tube_0c && (occ_4c[0].valid || occ_8c[0].valid)) || (t.tube_4c && m.valid) ||
              (t.tube_0c && m.valid && (m.rd == d.instr[19:15] || m.rd == d.instr[24:20] ||
                                        m.rd == d.instr[11:7]));
    o                 = '0;
    o.issue           = (g != GRP_NONE) && !blocked;
    o.tube_sel        = o.issue ? t : '0;
    o.alu_ctl         = model_alu(g, d.instr);
    o.pc_wr_en        = o.issue;
    o.branch          = (g == GRP_BRANCH);
    o.pc_sel_j        = (g == GRP_JAL);
    o.pc_sel_k        = (g == GRP_JALR);
    o.lane_y_sel_j    = g inside {GRP_AUIPC, GRP_LUI};
    o.lane_y_sel_k    = g inside {GRP_OPIMM, GRP_OP};
    o.lane_j_add_pc   = g inside {GRP_AUIPC, GRP_BRANCH, GRP_JAL};
    o.mem_rd_en       = o.issue && (g == GRP_LOAD);
    o.mem_wr_en       = o.issue && (g == GRP_STORE);
    o.mem_wr_ben      = !o.mem_wr_en ? 4'h0 : d.instr[14:12] == 3'd0 ? 4'h1 :
                        d.instr[14:12] == 3'd1 ? 4'h3 : d.instr[14:12] == 3'd2 ? 4'hf : 4'h0;
    o.reg_wr_en       = o.issue && !(g inside {GRP_STORE, GRP_BRANCH});
    o.reg_wr_size     = d.instr[13:12];
    o.reg_wr_sign_ext = !d.instr[14];
    o.reg_wr_addr     = d.instr[11:7];
    o.lane_a          = d.pc;
    o.lane_b          = (g == GRP_STORE) ? r2 :
                        g inside {GRP_OPIMM, GRP_OP, GRP_NONE} ? 32'h0 : imm;
    o.lane_c          = r1;
    o.lane_d          = g inside {GRP_OP, GRP_BRANCH} ? r2 :
                        g inside {GRP_LOAD, GRP_OPIMM, GRP_STORE, GRP_JALR} ? imm : 32'h0;
    return o;
endfunction

function automatic void clear_tubes();
    occ_4c.delete();
    occ_8c.delete();
    repeat (DEPTH_4C) occ_4c.push_back('0);
    repeat (DEPTH_8C) occ_8c.push_back('0);
endfunction

function automatic void advance_tubes(input tube_sel_t issued, input logic [4:0] rd);
    void'(occ_4c.pop_front());
    void'(occ_8c.pop_front());
    occ_4c.push_back({issued.tube_4c, rd});  // New entry enters the top slot
    occ_8c.push_back({issued.tube_8c, rd});
endfunction

function automatic logic tubes_busy();
    logic busy_4c;
    logic busy_8c;
    busy_4c = 1'b0;
    busy_8c = 1'b0;
    foreach (occ_4c[k]) busy_4c |= occ_4c[k].valid;
    foreach (occ_8c[k]) busy_8c |= occ_8c[k].valid;
    return busy_4c && busy_8c;
endfunction

`endif

// ==== tb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode import decode_pkg::*; ();

    localparam int unsigned DEPTH_4C = 4;
    localparam int unsigned DEPTH_8C = 8;
    localparam int unsigned SLOT_M   = DEPTH_8C - DEPTH_4C;
    localparam int N_GROUP  = 700;
    localparam int N_ALU    = 192;  // 4 passes x 3 groups x 8 funct3 x 2 values of bit 30
    localparam int N_MEXT   = 800;
    localparam int N_HAZARD = 900;
    localparam int N_MEM    = 384;
    localparam int N_RESET  = 24;
    localparam int TIMEOUT_CYCLES = N_GROUP + N_ALU + N_MEXT + N_HAZARD + N_MEM + N_RESET + 1000;
    localparam logic [6:0] OPCODES [9] = '{7'h03, 7'h13, 7'h17, 7'h23, 7'h33, 7'h37,
                                           7'h63, 7'h67, 7'h6f};
    localparam logic [6:0] UNSUPPORTED [5] = '{7'h0f, 7'h73, 7'h07, 7'h1b, 7'h2f};
    localparam logic [6:0] ALU_OPCODES [3] = '{7'h13, 7'h33, 7'h63};  // OP-IMM, OP, BRANCH

    logic            clk;
    logic            rst_n;
    decode_in_t      din;
    logic [XLEN-1:0] reg1;
    logic [XLEN-1:0] reg2;
    logic [4:0]      rd1_addr;
    logic [4:0]      rd2_addr;
    decode_out_t     dout;
    decode_out_t     last_exp;
    decode_out_t     last_got;
    string           cur_test;
    int              test_checks;
    int              test_errors;
    int              num_tests;
    int              total_checks;
    int              total_errors;
    int              cycles;

    `include "decode_model.svh"

    decode #(
        .TUBE_4C_DEPTH (DEPTH_4C),
        .TUBE_8C_DEPTH (DEPTH_8C)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .in           (din),
        .reg1         (reg1),
        .reg2         (reg2),
        .reg1_rd_addr (rd1_addr),
        .reg2_rd_addr (rd2_addr),
        .out          (dout)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rand_instr(input int unsigned mext_pct, input bit few_regs);
        logic [31:0] w;
        int unsigned pick;
        w = $urandom;
        if ($urandom_range(0, 99) < mext_pct) begin
            w[6:0]   = 7'h33;
            w[31:25] = 7'b0000001;
        end else begin
            pick = $urandom_range(0, 10);
            if (pick < 9) w[6:0] = OPCODES[pick];
            else if (pick == 9) w[6:0] = UNSUPPORTED[$urandom_range(0, 4)];
            if (w[6:0] == 7'h33) w[31:25] = {1'b0, w[30], 5'b0};  // ADD/SUB style funct7
        end
        if (few_regs) begin  // Small register set so hazards actually hit
            w[11:7]  = 5'($urandom_range(0, 3));
            w[19:15] = 5'($urandom_range(0, 3));
            w[24:20] = 5'($urandom_range(0, 3));
        end
        return w;
    endfunction

    task automatic step(input logic [31:0] w, input logic valid, input logic rst_val);
        @(negedge clk);
        rst_n           = rst_val;
        din.instr_valid = valid;
        din.instr       = w;
        din.pc          = $urandom & ~32'h3;
        reg1            = $urandom;
        reg2            = $urandom;
        #3;  // 1 ns before the rising edge
        last_exp = model_out(din, reg1, reg2);
        last_got = dout;
        test_checks++;
        assert (dout === last_exp) else begin
            $display("Error at %0t ns: %s instr %08h out %h, expected %h",
                     $time, cur_test, w, dout, last_exp);
            test_errors++;
        end
        assert (rd1_addr === w[19:15] && rd2_addr === w[24:20]) else begin
            $display("Error at %0t ns: %s read addresses %0d %0d for instr %08h",
                     $time, cur_test, rd1_addr, rd2_addr, w);
            test_errors++;
        end
        @(posedge clk);
        if (!rst_val) clear_tubes();
        else advance_tubes(last_exp.tube_sel, w[11:7]);
    endtask

    task automatic finish_test();
        $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        num_tests++;
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0] w;
        void'($urandom(32'h8b6a3a1f));
        rst_n = 1'b0;
        din   = '0;
        reg1  = '0;
        reg2  = '0;
        {test_checks, test_errors, num_tests, total_checks, total_errors} = '0;
        clear_tubes();
        repeat (2) @(posedge clk);

        cur_test = "group_decode";
        for (int i = 0; i < N_GROUP; i++) begin
            step(rand_instr(0, 1'b0), $urandom_range(0, 19) != 0, 1'b1);
        end
        finish_test();

        cur_test = "alu_ctl";
        for (int rep = 0; rep < 4; rep++)
            for (int g = 0; g < 3; g++)
                for (int f = 0; f < 8; f++)
                    for (int b = 0; b < 2; b++) begin
                        w        = $urandom;
                        w[6:0]   = ALU_OPCODES[g];
                        w[14:12] = 3'(f);
                        w[30]    = b[0];
                        if (g == 1) w[31:25] = {1'b0, b[0], 5'b0};
                        step(w, 1'b1, 1'b1);
                    end
        finish_test();

        cur_test = "mext_tubes";
        for (int i = 0; i < N_MEXT; i++) step(rand_instr(35, 1'b0), 1'b1, 1'b1);
        finish_test();

        cur_test = "hazard";
        for (int i = 0; i < N_HAZARD; i++) step(rand_instr(30, 1'b1), 1'b1, 1'b1);
        finish_test();

        cur_test = "load_store";
        for (int i = 0; i < N_MEM; i++) begin
            w        = $urandom;
            w[6:0]   = i[0] ? 7'h23 : 7'h03;
            w[14:12] = 3'(i % 3);  // Byte, half, word
            step(w, i >= DEPTH_8C, 1'b1);  // Idle first so the tubes drain
        end
        finish_test();

        cur_test = "reset_flush";
        for (int i = 0; i < N_RESET; i++) begin
            if (i == 12) begin
                assert (tubes_busy()) else begin
                    $display("Reset test: the tubes were not both occupied before reset");
                    test_errors++;
                end
            end
            if (i < 12) begin
                w     = rand_instr(100, 1'b0);
                w[14] = i[0];  // Alternate MUL and DIV
                step(w, 1'b1, 1'b1);
            end else if (i < 14) begin
                step($urandom, 1'b0, 1'b0);
            end else if (i == 14) begin
                step(32'h00100093, 1'b1, 1'b1);  // addi x1, x0, 1
                assert (last_got.issue) else begin
                    $display("Reset test: the first 0c instruction after reset did not issue");
                    test_errors++;
                end
            end else begin
                step(rand_instr(30, 1'b1), 1'b1, 1'b1);
            end
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", num_tests, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tube_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tube_tracker import decode_pkg::*; #(
    parameter int unsigned DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  tube_entry_t push,
    output tube_entry_t slots [DEPTH]
);

    logic [DEPTH-1:0]      valid_q;
    logic [REG_ADDR_W-1:0] rd_q [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {push.valid, valid_q[DEPTH-1:1]};  // Enter at the top, drain at 0
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH - 1; i++) begin
            rd_q[i] <= rd_q[i+1];
        end
        rd_q[DEPTH-1] <= push.rd;
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            slots[i] = '{valid: valid_q[i], rd: rd_q[i]};
        end
    end

endmodule

`default_nettype wire
